// ==== logic/sd_share_pkg.sv ====
/* Shared constants for the SD card switch */

package sd_share_pkg;

   //**********************************************************
   //* controller count
   //**********************************************************

   // disk controllers hanging on one card by default
   localparam int N_CTL_DEFAULT = 5;       // RK, DM, DW, DX, MY in the full board

   //**********************************************************
   //* request filter
   //**********************************************************

   // flop stages between a raw request and the dispatcher
   localparam int FILTER_DEPTH  = 2;       // two-flop synchronizer

   //**********************************************************
   //* card line levels with no owner
   //**********************************************************

   localparam logic SPI_CS_IDLE   = 1'b1;  // chip select deasserted
   localparam logic SPI_MOSI_IDLE = 1'b1;  // data line parked high
   localparam logic SPI_SCLK_IDLE = 1'b0;  // clock parked low, mode 0

   // these levels keep an unowned card deselected, so a controller that
   // toggles its lines without a grant never reaches the card
   // the card ignores mosi and sclk while cs is high

endpackage : sd_share_pkg

// ==== logic/sd_req_filter.sv ====
/* Request synchronizer for the SD card switch */

`timescale 1ns/1ps

module sd_req_filter #(
   parameter int N_CTL = sd_share_pkg::N_CTL_DEFAULT   // number of controllers
) (
   input  logic             sdclock,     // card clock
   input  logic             arst_n_i,    // async reset, active low
   input  logic [N_CTL-1:0] sd_req_i,    // raw requests from controllers
   output logic [N_CTL-1:0] req_filt_o   // filtered requests to dispatcher
);

   localparam int DEPTH = sd_share_pkg::FILTER_DEPTH;   // stages per request

   // stage_q[0] is the first flop after the raw line,
   // stage_q[DEPTH-1] is what the dispatcher sees
   logic [DEPTH-1:0][N_CTL-1:0] stage_q;   // shift chain, all bits in parallel

   //**********************************************************
   //* shift chain
   //**********************************************************

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         stage_q <= '0;                    // no requests seen after reset
      end else begin
         stage_q[0] <= sd_req_i;           // capture raw, may be metastable
         for (int i = 1; i < DEPTH; i++) begin
            stage_q[i] <= stage_q[i-1];    // settle through the chain
         end
      end
   end

   // last stage goes out
   assign req_filt_o = stage_q[DEPTH-1];   // DEPTH cycles behind sd_req_i

endmodule : sd_req_filter

// ==== logic/sd_grant_arbiter.sv ====
/* Priority dispatcher for the SD card switch */

`timescale 1ns/1ps

module sd_grant_arbiter #(
   parameter int N_CTL = sd_share_pkg::N_CTL_DEFAULT   // number of controllers
) (
   input  logic             sdclock,     // card clock
   input  logic             arst_n_i,    // async reset, active low
   input  logic [N_CTL-1:0] req_filt_i,  // filtered requests
   output logic [N_CTL-1:0] grant_o      // one-hot grant or zero
);

   typedef enum logic {
      ST_IDLE  = 1'b0,                     // card free, looking for a requester
      ST_OWNED = 1'b1                      // card held, waiting for release
   } state_t;

   state_t             state_q;            // current dispatcher state
   state_t             state_d;            // next state
   logic [N_CTL-1:0]   grant_q;            // registered grant
   logic [N_CTL-1:0]   grant_d;            // next grant
   logic [N_CTL-1:0]   pick;               // lowest-index request, one-hot
   logic               owner_drop;         // owner's request has fallen

   //**********************************************************
   //* priority pick
   //**********************************************************

   // walk from the top down so the lowest index is written last
   always_comb begin
      pick = '0;
      for (int i = N_CTL - 1; i >= 0; i--) begin
         if (req_filt_i[i]) begin
            pick    = '0;                  // drop any higher index
            pick[i] = 1'b1;                // this one wins so far
         end
      end
   end

   // grant bit set but its request gone
   assign owner_drop = |(grant_q & ~req_filt_i);

   //**********************************************************
   //* next state
   //**********************************************************

   always_comb begin
      state_d = state_q;                   // hold by default
      grant_d = grant_q;
      case (state_q)
         ST_IDLE: begin
            if (|req_filt_i) begin
               grant_d = pick;             // hand the card to the winner
               state_d = ST_OWNED;
            end
         end
         ST_OWNED: begin
            // other requests are ignored here, no preemption
            if (owner_drop) begin
               grant_d = '0;               // release, card idle next cycle
               state_d = ST_IDLE;
            end
         end
         default: begin
            grant_d = '0;                  // unreachable, park safely
            state_d = ST_IDLE;
         end
      endcase
   end

   //**********************************************************
   //* registers
   //**********************************************************

   always_ff @(posedge sdclock or negedge arst_n_i) begin
      if (!arst_n_i) begin
         state_q <= ST_IDLE;               // nobody owns the card
         grant_q <= '0;
      end else begin
         state_q <= state_d;
         grant_q <= grant_d;               // one cycle after req_filt_i
      end
   end

   assign grant_o = grant_q;               // straight from the flops

endmodule : sd_grant_arbiter

// ==== logic/sd_line_mux.sv ====
/* SPI line selector for the SD card switch */

`timescale 1ns/1ps

module sd_line_mux #(
   parameter int N_CTL = sd_share_pkg::N_CTL_DEFAULT   // number of controllers
) (
   input  logic [N_CTL-1:0] grant_i,       // one-hot grant or zero
   input  logic [N_CTL-1:0] ctl_cs_i,      // chip select per controller
   input  logic [N_CTL-1:0] ctl_mosi_i,    // mosi per controller
   input  logic [N_CTL-1:0] ctl_sclk_i,    // sclk per controller
   output logic             sdcard_cs_o,   // chip select to card
   output logic             sdcard_mosi_o, // mosi to card
   output logic             sdcard_sclk_o  // sclk to card
);

   logic card_owned;                       // some controller holds the card

   // one selector for all three lines
   // with a one-hot grant the AND-OR leaves only the owner's bit
   function automatic logic sel_line(
      input logic [N_CTL-1:0] grant,       // one-hot or zero
      input logic [N_CTL-1:0] lines,       // one bit per controller
      input logic             owned,       // grant present
      input logic             idle         // level with no owner
   );
      logic picked;                        // owner's bit
      picked = |(grant & lines);
      return owned ? picked : idle;
   endfunction

   //**********************************************************
   //* card lines
   //**********************************************************

   assign card_owned = |grant_i;

   // pure combinational path, zero cycles from grant to pins
   assign sdcard_cs_o   = sel_line(grant_i, ctl_cs_i,   card_owned,
                                   sd_share_pkg::SPI_CS_IDLE);     // deselect when free
   assign sdcard_mosi_o = sel_line(grant_i, ctl_mosi_i, card_owned,
                                   sd_share_pkg::SPI_MOSI_IDLE);   // park high
   assign sdcard_sclk_o = sel_line(grant_i, ctl_sclk_i, card_owned,
                                   sd_share_pkg::SPI_SCLK_IDLE);   // park low

   // miso is not switched here, it fans out to all controllers

endmodule : sd_line_mux

// ==== logic/sd_share_top.sv ====
/* SD card switch between disk controllers */

`timescale 1ns/1ps

module sd_share_top #(
   parameter int N_CTL = sd_share_pkg::N_CTL_DEFAULT   // controllers on the card
) (
   input  logic             sdclock,       // card clock
   input  logic             arst_n_i,      // async reset, active low

   // controller side
   input  logic [N_CTL-1:0] sd_req_i,      // card requests, held while in use
   output logic [N_CTL-1:0] sd_ack_o,      // grants, at most one high
   input  logic [N_CTL-1:0] ctl_cs_i,      // controllers' chip selects
   input  logic [N_CTL-1:0] ctl_mosi_i,    // controllers' mosi
   input  logic [N_CTL-1:0] ctl_sclk_i,    // controllers' sclk

   // card side
   output logic             sdcard_cs_o,   // chip select to card
   output logic             sdcard_mosi_o, // mosi to card
   output logic             sdcard_sclk_o  // sclk to card
);

   logic [N_CTL-1:0] req_filt;             // synchronized requests
   logic [N_CTL-1:0] grant;                // registered one-hot grant

   //**********************************************************
   //* request synchronizer
   //**********************************************************

   sd_req_filter #(
      .N_CTL      (N_CTL)
   ) u_req_filter (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .sd_req_i   (sd_req_i),              // raw, from any clock domain
      .req_filt_o (req_filt)
   );

   //**********************************************************
   //* dispatcher
   //**********************************************************

   sd_grant_arbiter #(
      .N_CTL      (N_CTL)
   ) u_grant_arbiter (
      .sdclock    (sdclock),
      .arst_n_i   (arst_n_i),
      .req_filt_i (req_filt),
      .grant_o    (grant)                  // 3 edges after sd_req_i
   );

   //**********************************************************
   //* card line switch
   //**********************************************************

   sd_line_mux #(
      .N_CTL         (N_CTL)
   ) u_line_mux (
      .grant_i       (grant),
      .ctl_cs_i      (ctl_cs_i),
      .ctl_mosi_i    (ctl_mosi_i),
      .ctl_sclk_i    (ctl_sclk_i),
      .sdcard_cs_o   (sdcard_cs_o),
      .sdcard_mosi_o (sdcard_mosi_o),
      .sdcard_sclk_o (sdcard_sclk_o)
   );

   assign sd_ack_o = grant;                // controllers see the same grant

endmodule : sd_share_top

// ==== testbench/tb_clock_gen.sv ====
/* Clock and reset for the SD switch testbench */

`timescale 1ns/1ps

module tb_clock_gen (
   output logic sdclock,                   // card clock
   output logic arst_n_o                   // async reset, active low
);

   localparam int PERIOD_NS    = 4;        // 250 MHz
   localparam int RESET_CYCLES = 3;        // rising edges seen in reset

   initial begin
      sdclock = 1'b0;
      forever #(PERIOD_NS / 2) sdclock = ~sdclock;
   end

   // release on an edge, flops still see reset low at that edge
   initial begin
      arst_n_o = 1'b0;
      repeat (RESET_CYCLES) @(posedge sdclock);
      arst_n_o <= 1'b1;                    // out of reset after 3 cycles
   end

endmodule : tb_clock_gen

// ==== testbench/sd_share_tb.sv ====
/* Testbench for the SD card switch */

`timescale 1ns/1ps

module sd_share_tb;

   localparam int N_CTL     = 5;           // controllers on the card
   localparam int MAX_TESTS = 64;          // room for test steps

   logic             sdclock;              // from clock gen
   logic             arst_n;               // from clock gen
   logic [N_CTL-1:0] sd_req;               // requests into DUT
   logic [N_CTL-1:0] sd_ack;               // grants out of DUT
   logic [N_CTL-1:0] ctl_cs;               // controller chip selects
   logic [N_CTL-1:0] ctl_mosi;             // controller mosi
   logic [N_CTL-1:0] ctl_sclk;             // controller sclk
   logic             card_cs;              // card side
   logic             card_mosi;
   logic             card_sclk;

   //**********************************************************
   //* test table, filled from the tests file
   //**********************************************************

   string            t_name  [MAX_TESTS];  // step name
   int               t_hold  [MAX_TESTS];  // cycles to hold the inputs
   logic [N_CTL-1:0] t_req   [MAX_TESTS];  // request vector
   logic [N_CTL-1:0] t_cs    [MAX_TESTS];  // per-controller lines
   logic [N_CTL-1:0] t_mosi  [MAX_TESTS];
   logic [N_CTL-1:0] t_sclk  [MAX_TESTS];
   logic [N_CTL-1:0] t_ack   [MAX_TESTS];  // expected grant
   logic             t_ecs   [MAX_TESTS];  // expected card lines
   logic             t_emosi [MAX_TESTS];
   logic             t_esclk [MAX_TESTS];

   int          n_tests     = 0;           // steps loaded
   int          total_hold  = 0;           // sum of hold counts
   int          cycle_limit = 23;          // raised once the file is read
   int          cycle_cnt   = 0;           // rising edges since start
   int          value_errs  = 0;           // wrong outputs
   int          other_errs  = 0;           // file trouble, timeout
   logic [31:0] lfsr_q;                    // noise generator state

   tb_clock_gen u_clock_gen (
      .sdclock  (sdclock),
      .arst_n_o (arst_n)
   );

   sd_share_top #(
      .N_CTL         (N_CTL)
   ) UUT (
      .sdclock       (sdclock),
      .arst_n_i      (arst_n),
      .sd_req_i      (sd_req),
      .sd_ack_o      (sd_ack),
      .ctl_cs_i      (ctl_cs),
      .ctl_mosi_i    (ctl_mosi),
      .ctl_sclk_i    (ctl_sclk),
      .sdcard_cs_o   (card_cs),
      .sdcard_mosi_o (card_mosi),
      .sdcard_sclk_o (card_sclk)
   );

   //**********************************************************
   //* noise for lines of controllers without the card
   //**********************************************************

   // x^32 + x^22 + x^2 + x + 1
   function automatic logic [31:0] lfsr_next(input logic [31:0] s);
      logic fb;
      fb = s[31] ^ s[21] ^ s[1] ^ s[0];
      return {s[30:0], fb};
   endfunction

   task automatic next_rand_bits(output logic [N_CTL-1:0] bits);
      int i;
      for (i = 0; i < N_CTL; i++) begin
         lfsr_q  = lfsr_next(lfsr_q);      // one step per bit
         bits[i] = lfsr_q[0];
      end
   endtask

   task automatic report_counts();
      $display("errors: %0d wrong values, %0d other failures", value_errs, other_errs);
   endtask

   task automatic load_tests();
      int               fd;
      int               n;
      string            line;
      string            name;
      int               hold;
      logic [N_CTL-1:0] req, cs, mosi, sclk, ack;
      logic             ecs, emosi, esclk;
      fd = $fopen("testbench/sd_share_tests.txt", "r");
      if (fd == 0) begin
         other_errs++;
         $display("could not open testbench/sd_share_tests.txt for reading");
         return;
      end
      while (!$feof(fd)) begin
         line = "";
         n = $fgets(line, fd);
         if (n > 0 && line.len() > 1 && line.getc(0) != "#") begin   // skip notes, blanks
            n = $sscanf(line, "%s %d %b %b %b %b %b %b %b %b", name, hold,
                        req, cs, mosi, sclk, ack, ecs, emosi, esclk);
            if (n != 10) begin
               other_errs++;
               $display("a line of the tests file could not be read: %s", line);
            end else if (n_tests >= MAX_TESTS) begin
               other_errs++;
               $display("the tests file holds more than %0d steps", MAX_TESTS);
            end else begin
               t_name[n_tests]  = name;
               t_hold[n_tests]  = hold;
               t_req[n_tests]   = req;
               t_cs[n_tests]    = cs;
               t_mosi[n_tests]  = mosi;
               t_sclk[n_tests]  = sclk;
               t_ack[n_tests]   = ack;
               t_ecs[n_tests]   = ecs;
               t_emosi[n_tests] = emosi;
               t_esclk[n_tests] = esclk;
               total_hold += hold;
               n_tests++;
            end
         end
      end
      $fclose(fd);
      cycle_limit = total_hold + 3 + 20;   // holds, reset, slack
   endtask

   //**********************************************************
   //* checks
   //**********************************************************

   task automatic compare_bit(input string step, input string sig,
                              input logic exp, input logic act);
      assert (act === exp) else begin
         value_errs++;
         $display("ERR %s %s expected %b actual %b", step, sig, exp, act);
      end
   endtask

   task automatic check_outputs(input string step, input logic [N_CTL-1:0] ack,
                                input logic ecs, input logic emosi, input logic esclk);
      assert (sd_ack === ack) else begin
         value_errs++;
         $display("ERR %s sd_ack_o expected %b actual %b", step, ack, sd_ack);
      end
      compare_bit(step, "sdcard_cs_o", ecs, card_cs);
      compare_bit(step, "sdcard_mosi_o", emosi, card_mosi);
      compare_bit(step, "sdcard_sclk_o", esclk, card_sclk);
   endtask

   // drive one step, wait out its hold, check in the last cycle
   task automatic run_step(input int t);
      logic [N_CTL-1:0] noise_cs, noise_mosi, noise_sclk;
      logic [N_CTL-1:0] others;            // controllers that should not own the card
      next_rand_bits(noise_cs);
      next_rand_bits(noise_mosi);
      next_rand_bits(noise_sclk);
      others = ~t_ack[t];
      if (t_hold[t] < sd_share_pkg::FILTER_DEPTH + 2) begin
         other_errs++;
         $display("step %s holds only %0d cycles, shorter than the grant latency",
                  t_name[t], t_hold[t]);
      end
      @(posedge sdclock);
      sd_req   <= t_req[t];
      ctl_cs   <= t_cs[t]   ^ (noise_cs   & others);   // owner's bits as written
      ctl_mosi <= t_mosi[t] ^ (noise_mosi & others);
      ctl_sclk <= t_sclk[t] ^ (noise_sclk & others);
      repeat (t_hold[t] - 1) @(posedge sdclock);
      @(negedge sdclock);                  // outputs settled
      check_outputs(t_name[t], t_ack[t], t_ecs[t], t_emosi[t], t_esclk[t]);
   endtask

   //**********************************************************
   //* main sequence
   //**********************************************************

   initial begin
      int t;
      sd_req   = '0;
      ctl_cs   = '0;
      ctl_mosi = '0;
      ctl_sclk = '0;
      lfsr_q   = 32'he700;                 // fixed seed
      load_tests();
      if (n_tests == 0) begin
         other_errs++;
         $display("no test steps were loaded");
      end
      @(negedge sdclock);                  // still inside reset
      check_outputs("in_reset", '0, sd_share_pkg::SPI_CS_IDLE,
                    sd_share_pkg::SPI_MOSI_IDLE, sd_share_pkg::SPI_SCLK_IDLE);
      wait (arst_n === 1'b1);
      for (t = 0; t < n_tests; t++) begin
         run_step(t);
      end
      report_counts();
      if (value_errs + other_errs == 0) begin
         $display("Testbench passed");
      end else begin
         $display("Testbench failed");
      end
      $finish;
   end

   // watchdog on the total length of the steps
   always @(posedge sdclock) begin
      cycle_cnt <= cycle_cnt + 1;
      if (cycle_cnt >= cycle_limit) begin
         other_errs++;
         $display("timeout: the run did not finish within %0d cycles", cycle_limit);
         report_counts();
         $display("Testbench failed");
         $finish;
      end
   end

endmodule : sd_share_tb

// ==== testbench/sd_share_tests.txt ====
# name hold req[4:0] cs[4:0] mosi[4:0] sclk[4:0] exp_ack[4:0] exp_cs exp_mosi exp_sclk
# vectors are binary, bit 0 on the right is controller 0 with the highest priority
#
# idle after reset, card lines parked even while controllers drive the other way
reset_idle        4 00000 11111 11111 00000 00000 1 1 0
idle_lines_busy   4 00000 00000 00000 11111 00000 1 1 0
#
# a lone request, card follows controller 2 through several patterns
single_c2_a       4 00100 00000 00100 00000 00100 0 1 0
single_c2_b       4 00100 00100 00000 00100 00100 1 0 1
single_c2_c       4 00100 00100 00100 00100 00100 1 1 1
single_c2_d       4 00100 11011 11011 11011 00100 0 0 0
release_c2        4 00000 00100 00100 00100 00000 1 1 0
#
# several requests rise together, controller 1 is the lowest index
multi_rise        4 11010 00000 00010 00010 00010 0 1 1
#
# controller 0 arrives while 1 owns the card, no preemption
no_preempt        4 11011 11101 00000 11111 00010 0 0 1
no_preempt_hold   6 11011 00010 11101 00000 00010 1 0 0
#
# owner drops, lowest pending wins after one idle cycle
handoff_to_c0     5 11001 00000 00001 00000 00001 0 1 0
c0_patterns       4 11001 00001 00000 00001 00001 1 0 1
handoff_to_c3     5 11000 00000 01000 01000 01000 0 1 1
late_low_req      4 11010 10111 10111 01000 01000 0 0 1
handoff_to_c1     5 10010 00000 00000 00010 00010 0 0 1
handoff_to_c4     5 10000 00000 10000 00000 10000 0 1 0
c4_patterns       4 10000 10000 00000 10000 10000 1 0 1
#
# all requests gone, card parked again
all_drop          4 00000 00000 00000 11111 00000 1 1 0
idle_after_drop   4 00000 10101 01010 10101 00000 1 1 0
#
# owner 3 drops as 2 raises, the card stays idle for a cycle first
regrant_c3        4 01000 00000 01000 00000 01000 0 1 0
gap_before_c2     4 00100 00000 00000 00000 00000 1 1 0
grant_c2          4 00100 00000 00000 00100 00100 0 0 1
final_drop        4 00000 11111 00000 11111 00000 1 1 0

// ==== flist.f ====
logic/sd_share_pkg.sv
logic/sd_req_filter.sv
logic/sd_grant_arbiter.sv
logic/sd_line_mux.sv
logic/sd_share_top.sv
testbench/tb_clock_gen.sv
testbench/sd_share_tb.sv

// ==== Bender.yml ====
package:
  name: sd_share

sources:
  - logic/sd_share_pkg.sv
  - logic/sd_req_filter.sv
  - logic/sd_grant_arbiter.sv
  - logic/sd_line_mux.sv
  - logic/sd_share_top.sv
  - target: test
    files:
      - testbench/tb_clock_gen.sv
      - testbench/sd_share_tb.sv
